// File: src.f
+incdir+.
vec_types_pkg.sv
vec_uop_gen_if.sv
vec_opi_decode.sv
vec_opm_decode.sv
vec_uop_gen.sv
vec_decode_unit.sv
vec_decode_top.sv
tb_vec_decode.sv

// File: tb_vec_decode.sv
// #########################################################
// Vector decode testbench
// #########################################################
`timescale 1ns/100ps
`include "vec_consts.svh"

module tb_vec_decode;
    import vec_types_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_LINES  = 64;

    logic                 CLK;
    logic                 reset;
    logic [31:0]          instr;
    logic                 vvalid;
    logic                 stall;
    vsew_t                vsew;
    logic [`VEC_VL_W-1:0] vl;
    vcontrol_t            vcontrol;
    logic                 vissue;
    logic                 vbusy;
    logic                 vdecode_err;

    // Golden columns
    logic [31:0] gold_instr [MAX_LINES];
    logic [31:0] gold_vsew [MAX_LINES];
    logic [31:0] gold_vl [MAX_LINES];
    logic [31:0] gold_cfg [MAX_LINES];
    logic [31:0] gold_sregwen [MAX_LINES];
    logic [31:0] gold_vregwen [MAX_LINES];
    logic [31:0] gold_rden [MAX_LINES];
    logic [31:0] gold_wren [MAX_LINES];
    logic [31:0] gold_src2 [MAX_LINES];
    logic [31:0] gold_dest [MAX_LINES];
    logic [31:0] gold_vfu [MAX_LINES];
    logic [31:0] gold_err [MAX_LINES];
    int          num_lines;
    int          max_n;
    logic        load_done;
    logic [31:0] lfsr;

    vec_decode_top dut0 (
        .CLK         (CLK),
        .reset       (reset),
        .instr       (instr),
        .vvalid      (vvalid),
        .stall       (stall),
        .vsew        (vsew),
        .vl          (vl),
        .vcontrol    (vcontrol),
        .vissue      (vissue),
        .vbusy       (vbusy),
        .vdecode_err (vdecode_err)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Ceiling of vl over elements per micro-op, never below one
    function automatic int count_uops(input logic [31:0] sew, input logic [31:0] vlen);
        int per;
        int n;
        per = (`VEC_LANES * 4) >> sew;
        n = (int'(vlen) + per - 1) / per;
        if (n < 1) begin
            n = 1;
        end
        return n;
    endfunction

    function automatic logic [`VEC_LANES-1:0] lane_mask(input logic [31:0] sew,
                                                       input logic [31:0] vlen,
                                                       input int num);
        int                    epw;
        logic [`VEC_LANES-1:0] m;
        // Elements per 32-bit word
        epw = 4 >> sew;
        for (int i = 0; i < `VEC_LANES; i++) begin
            m[i] = ((num * `VEC_LANES + i) * epw) < vlen;
        end
        return m;
    endfunction

    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, field, got, exp);
            $display("Something failed");
            $fatal(1, "Check on %s failed", field);
        end
    endtask

    task automatic read_golden();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] col [12];
        fd = $fopen("vec_decode_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open vec_decode_golden.txt for reading");
            $display("Something failed");
            $fatal(1, "No stimulus file");
        end
        num_lines = 0;
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            // Skip comments and blank lines
            if (cnt == 0 || line.len() < 8 || line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                          col[0], col[1], col[2], col[3], col[4], col[5],
                          col[6], col[7], col[8], col[9], col[10], col[11]);
            if (cnt != 12 || num_lines >= MAX_LINES) begin
                $display("Golden file line %0d is malformed or beyond capacity", num_lines);
                $display("Something failed");
                $fatal(1, "Bad stimulus file");
            end
            gold_instr[num_lines]   = col[0];
            gold_vsew[num_lines]    = col[1];
            gold_vl[num_lines]      = col[2];
            gold_cfg[num_lines]     = col[3];
            gold_sregwen[num_lines] = col[4];
            gold_vregwen[num_lines] = col[5];
            gold_rden[num_lines]    = col[6];
            gold_wren[num_lines]    = col[7];
            gold_src2[num_lines]    = col[8];
            gold_dest[num_lines]    = col[9];
            gold_vfu[num_lines]     = col[10];
            gold_err[num_lines]     = col[11];
            num_lines++;
        end
        $fclose(fd);
    endtask

    // Two LFSR bits, stall one cycle in four
    task automatic draw_stall(output logic s);
        logic b0;
        logic b1;
        lfsr = lfsr_next(lfsr);
        b0 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1 = lfsr[0];
        s = b0 & b1;
    endtask

    task automatic check_static(input int k);
        check_value("vsetvl_type", 32'(vcontrol.vsetvl_type), gold_cfg[k]);
        check_value("sregwen", 32'(vcontrol.sregwen), gold_sregwen[k]);
        check_value("vregwen", 32'(vcontrol.vregwen), gold_vregwen[k]);
        check_value("vmemrden", 32'(vcontrol.vmemrden), gold_rden[k]);
        check_value("vmemwren", 32'(vcontrol.vmemwren), gold_wren[k]);
        check_value("veew_src2", 32'(vcontrol.veew_src2), gold_src2[k]);
        check_value("veew_dest", 32'(vcontrol.veew_dest), gold_dest[k]);
        check_value("vexec.vfu", 32'(vcontrol.vexec.vfu), gold_vfu[k]);
        check_value("vdecode_err", 32'(vdecode_err), gold_err[k]);
    endtask

    task automatic check_uop(input int k, input int num);
        int          roff;
        logic [4:0]  vd;
        logic [4:0]  vs1;
        logic [4:0]  vs2;
        logic [4:0]  src1;
        logic [5:0]  exp_vd_sel;
        roff = (num / `VEC_LANES) % `VEC_MAX_GROUP;
        vd   = gold_instr[k][11:7];
        vs1  = gold_instr[k][19:15];
        vs2  = gold_instr[k][24:20];
        // Store data register vs3 sits in the vd field
        src1 = gold_wren[k][0] ? vd : vs1;
        // Scalar destination keeps its index, vector ones step with the group
        exp_vd_sel = gold_sregwen[k][0] ? {1'b0, vd} : {1'b1, 5'(vd + roff)};
        check_value("vbank_offset", 32'(vcontrol.vbank_offset), num & 1);
        check_value("vlaneactive", 32'(vcontrol.vlaneactive),
                    32'(lane_mask(gold_dest[k], gold_vl[k], num)));
        check_value("vd_sel", 32'(vcontrol.vd_sel), 32'(exp_vd_sel));
        check_value("vs1_sel", 32'(vcontrol.vs1_sel), 32'({1'b1, 5'(src1 + roff)}));
        check_value("vs2_sel", 32'(vcontrol.vs2_sel), 32'({1'b1, 5'(vs2 + roff)}));
    endtask

    // Hold one instruction until all its micro-ops are out
    task automatic run_instr(input int k);
        int   n;
        int   issued;
        logic stall_now;
        n = count_uops(gold_dest[k], gold_vl[k]);
        issued = 0;
        while (issued < n) begin
            @(negedge CLK);
            draw_stall(stall_now);
            instr  = gold_instr[k];
            vvalid = 1'b1;
            stall  = stall_now;
            vsew   = vsew_t'(gold_vsew[k][1:0]);
            vl     = gold_vl[k][`VEC_VL_W-1:0];
            #(CLK_PERIOD / 4);
            check_static(k);
            check_value("vissue", 32'(vissue), 32'(!stall_now));
            check_value("vbusy", 32'(vbusy), 32'(issued != 0));
            // Counter holds through stalls
            check_value("vuop_num", 32'(vcontrol.vuop_num), issued);
            if (!stall_now) begin
                check_uop(k, issued);
                issued++;
            end
        end
    endtask

    task automatic idle_cycle();
        @(negedge CLK);
        vvalid = 1'b0;
        stall  = 1'b0;
        #(CLK_PERIOD / 4);
        check_value("vissue", 32'(vissue), 0);
        check_value("vbusy", 32'(vbusy), 0);
        check_value("vuop_num", 32'(vcontrol.vuop_num), 0);
        check_value("vdecode_err", 32'(vdecode_err), 0);
    endtask

    // Watchdog sized by line count and longest instruction
    initial begin
        wait (load_done === 1'b1);
        repeat (8 + num_lines * (max_n + 20)) @(posedge CLK);
        $display("Timeout: the DUT hung and the micro-op sequence did not complete");
        $display("Something failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        reset     = 1'b1;
        instr     = '0;
        vvalid    = 1'b0;
        stall     = 1'b0;
        vsew      = SEW8;
        vl        = '0;
        lfsr      = 32'h87ec;
        load_done = 1'b0;
        max_n     = 1;
        read_golden();
        for (int k = 0; k < num_lines; k++) begin
            if (count_uops(gold_dest[k], gold_vl[k]) > max_n) begin
                max_n = count_uops(gold_dest[k], gold_vl[k]);
            end
        end
        load_done = 1'b1;

        repeat (8) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;
        // Generator idle out of reset
        idle_cycle();

        for (int k = 0; k < num_lines; k++) begin
            run_instr(k);
            idle_cycle();
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: vec_consts.svh
// #########################################################
// Vector decode constants
// #########################################################
`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// 32-bit lanes per micro-op
`define VEC_LANES 2

// Largest register group, sizes the register offset
`define VEC_MAX_GROUP 8

// Width of the vl input
`define VEC_VL_W 8

`endif

// File: vec_decode_golden.txt
# instr vsew vl vsetvl sregwen vregwen memrden memwren veew_src2 veew_dest vfu decode_err, all hex
# sew 0=e8 1=e16 2=e32; vfu 0 alu 1 mul 2 red 3 msk 4 prm 5 mov
02056207 0 05 0 0 1 1 0 0 2 0 0
06228407 1 07 0 0 1 1 0 0 1 0 0
0200D1A7 2 09 0 0 0 0 1 2 1 0 0
0A310087 2 0B 0 0 1 1 0 2 0 0 0
0E93E327 0 0C 0 0 0 0 1 2 0 0 0
02430157 1 06 0 0 1 0 0 1 1 0 0
9701B457 2 07 0 0 1 0 0 2 2 0 0
32C2C557 0 14 0 0 1 0 0 0 0 4 0
B22180D7 0 0A 0 0 1 0 0 1 0 0 0
C6800257 1 03 0 0 1 0 0 1 2 2 0
9663A2D7 2 05 0 0 1 0 0 2 2 1 0
E221E457 0 0D 0 0 1 0 0 0 1 1 0
0221A0D7 1 04 0 0 1 0 0 1 1 2 0
6621A0D7 0 10 0 0 1 0 0 0 0 3 0
424022D7 2 01 0 1 0 0 0 2 2 5 0
010170D7 0 03 1 1 0 0 0 0 0 0 0
C08271D7 1 02 2 1 0 0 0 1 1 0 0
8062F257 2 02 3 1 0 0 0 2 2 0 0
00110093 1 05 0 0 0 0 0 1 1 0 1
061080D7 0 09 0 0 1 0 0 0 0 0 1
2210A0D7 2 03 0 0 1 0 0 2 2 0 1
022190D7 1 01 0 0 1 0 0 1 1 0 1
02430157 2 00 0 0 1 0 0 2 2 0 0
02430157 2 1D 0 0 1 0 0 2 2 0 0

// File: vec_decode_top.sv
// #########################################################
// Vector decode top level
// #########################################################
`timescale 1ns/100ps
`include "vec_consts.svh"

module vec_decode_top (
    input  logic                      CLK,
    input  logic                      reset,
    input  logic [31:0]               instr,
    // Held steady while vbusy is high
    input  logic                      vvalid,
    input  logic                      stall,
    input  vec_types_pkg::vsew_t      vsew,
    input  logic [`VEC_VL_W-1:0]      vl,
    output vec_types_pkg::vcontrol_t  vcontrol,
    output logic                      vissue,
    output logic                      vbusy,
    output logic                      vdecode_err
);

    vec_decode_unit u_decode_unit (
        .CLK         (CLK),
        .reset       (reset),
        .instr       (instr),
        .vvalid      (vvalid),
        .stall       (stall),
        .vsew        (vsew),
        .vl          (vl),
        .vcontrol    (vcontrol),
        .vissue      (vissue),
        .vbusy       (vbusy),
        .vdecode_err (vdecode_err)
    );

endmodule

// File: vec_decode_unit.sv
// #########################################################
// Vector instruction decode
// #########################################################
`timescale 1ns/100ps
`include "vec_consts.svh"

module vec_decode_unit (
    input  logic                      CLK,
    input  logic                      reset,
    input  logic [31:0]               instr,
    input  logic                      vvalid,
    input  logic                      stall,
    input  vec_types_pkg::vsew_t      vsew,
    input  logic [`VEC_VL_W-1:0]      vl,
    output vec_types_pkg::vcontrol_t  vcontrol,
    output logic                      vissue,
    output logic                      vbusy,
    output logic                      vdecode_err
);
    import vec_types_pkg::*;

    logic [4:0]    vd, vs1, vs2, roff;
    vmajoropcode_t vmajor;
    vfunct3_t      vfunct3;
    mop_t          mop;
    width_t        vmem_width;
    vopi_t         vopi;
    vopm_t         vopm;
    logic          vmajor_valid, vload, vstore, valu, vcfg, vmeminstr;
    logic          is_opi, is_opm, sregwen;
    logic          vunitstride, vstrided, vindexed, vwidening, vnarrowing;
    vsew_t         vmem_eew, twice_vsew, veew_src2, veew_dest;
    vexec_t        vexec_opi, vexec_opm;
    logic          vopi_valid, vopm_valid, vexec_valid;

    // Field extraction, vd doubles as store data vs3
    assign vd         = instr[11:7];
    assign vs1        = instr[19:15];
    assign vs2        = instr[24:20];
    assign vmajor     = vmajoropcode_t'(instr[6:0]);
    assign vfunct3    = vfunct3_t'(instr[14:12]);
    assign vmem_width = width_t'(instr[14:12]);
    assign mop        = mop_t'(instr[27:26]);
    assign vopi       = vopi_t'(instr[31:26]);
    assign vopm       = vopm_t'(instr[31:26]);

    // Instruction class
    assign vmajor_valid = vmajor inside {VMOC_LOAD, VMOC_STORE, VMOC_ALU_CFG};
    assign vload        = (vmajor == VMOC_LOAD);
    assign vstore       = (vmajor == VMOC_STORE);
    assign valu         = (vmajor == VMOC_ALU_CFG);
    assign vmeminstr    = vload || vstore;
    assign vcfg         = valu && (vfunct3 == OPCFG);
    assign is_opi       = valu && (vfunct3 inside {OPIVV, OPIVI, OPIVX});
    assign is_opm       = valu && (vfunct3 inside {OPMVV, OPMVX});

    // vset* kind from the top bits
    always_comb begin
        vcontrol.vsetvl_type = NOT_CFG;
        vcontrol.vtype_imm   = '0;
        if (vcfg) begin
            if (!instr[31]) begin
                vcontrol.vsetvl_type = VSETVLI;
                vcontrol.vtype_imm   = instr[30:20];
            end else if (instr[30]) begin
                vcontrol.vsetvl_type = VSETIVLI;
                vcontrol.vtype_imm   = {1'b0, instr[29:20]};
            end else begin
                vcontrol.vsetvl_type = VSETVL;
            end
        end
    end
    assign vcontrol.vimm = vs1;

    // Write enables, vset* and vmv.x.s write the scalar file
    assign sregwen          = vcfg || (valu && vfunct3 == OPMVV && vopm == VWXUNARY0);
    assign vcontrol.sregwen = sregwen;
    assign vcontrol.vregwen = vmajor_valid && !sregwen && !vstore;

    // Operand sources
    assign vcontrol.vxin1_use_imm = valu && (vfunct3 == OPIVI);
    assign vcontrol.vxin1_use_rs1 = vmeminstr || (valu && vfunct3 inside {OPIVX, OPFVF, OPMVX});
    // Stride comes from rs2
    assign vcontrol.vxin2_use_rs2 = vstrided;

    // Memory flags
    assign vunitstride = vmeminstr && (mop == MOP_UNIT);
    assign vstrided    = vmeminstr && (mop == MOP_STRIDED);
    assign vindexed    = vmeminstr && (mop inside {MOP_UINDEXED, MOP_OINDEXED});

    assign vcontrol.vmemrden    = vload;
    assign vcontrol.vmemwren    = vstore;
    assign vcontrol.vunitstride = vunitstride;
    assign vcontrol.vstrided    = vstrided;
    assign vcontrol.vindexed    = vindexed;

    // Element widths
    assign vmem_eew   = (vmem_width == WIDTH8)  ? SEW8 :
                        (vmem_width == WIDTH16) ? SEW16 : SEW32;
    // One step up the width encoding
    assign twice_vsew = vsew_t'(2'(vsew) + 2'd1);
    assign vwidening  = (is_opi || is_opm) && (instr[31:30] == 2'b11);
    assign vnarrowing = is_opi && (vopi inside {VNSRL, VNSRA});

    // Index operand in vs2 uses the width field
    assign veew_src2 = vindexed   ? vmem_eew :
                       vnarrowing ? twice_vsew : vsew;
    // Indexed data follows vsew, other memory data the width field
    assign veew_dest = (vunitstride || vstrided) ? vmem_eew :
                       vindexed                  ? vsew :
                       vwidening                 ? twice_vsew : vsew;

    assign vcontrol.veew_src1 = vsew;
    assign vcontrol.veew_src2 = veew_src2;
    assign vcontrol.veew_dest = veew_dest;

    vec_opi_decode u_opi_decode (
        .vopi  (vopi),
        .vexec (vexec_opi),
        .valid (vopi_valid)
    );

    vec_opm_decode u_opm_decode (
        .vopm  (vopm),
        .vexec (vexec_opm),
        .valid (vopm_valid)
    );

    // Execute op select
    always_comb begin
        vexec_valid    = 1'b1;
        vcontrol.vexec = '0;
        if (vmeminstr) begin
            // Unsigned add for address generation
            vcontrol.vexec.valuop      = VALU_ADD;
            vcontrol.vexec.vopunsigned = 1'b1;
        end else if (is_opi && vopi_valid) begin
            vcontrol.vexec = vexec_opi;
        end else if (is_opm && vopm_valid) begin
            vcontrol.vexec = vexec_opm;
        end else begin
            vexec_valid = 1'b0;
        end
    end

    assign vdecode_err = vvalid && (!vmajor_valid || !(vexec_valid || vcfg));

    // Micro-op generator
    vec_uop_gen_if vug_if ();

    assign vug_if.gen_valid = vvalid;
    assign vug_if.stall     = stall;
    assign vug_if.veew      = veew_dest;
    assign vug_if.vl        = vl;

    vec_uop_gen u_uop_gen (
        .CLK    (CLK),
        .reset  (reset),
        .vug_if (vug_if)
    );

    // Register selects step with the group offset
    assign roff = 5'(vug_if.vreg_offset);
    assign vcontrol.vd_sel  = sregwen ? regsel_t'{regclass: RC_SCALAR, regidx: vd} :
                                        regsel_t'{regclass: RC_VECTOR, regidx: vd + roff};
    assign vcontrol.vs1_sel = regsel_t'{regclass: RC_VECTOR,
                                        regidx: (vstore ? vd : vs1) + roff};
    assign vcontrol.vs2_sel = regsel_t'{regclass: RC_VECTOR, regidx: vs2 + roff};

    assign vcontrol.vuop_num     = vug_if.vuop_num;
    assign vcontrol.vbank_offset = vug_if.vbank_offset;
    assign vcontrol.vlaneactive  = vug_if.vlane_active;
    assign vissue                = vug_if.issue;
    assign vbusy                 = vug_if.busy;

endmodule

// File: vec_opi_decode.sv
// #########################################################
// OPI funct6 decoder
// #########################################################
`timescale 1ns/100ps

module vec_opi_decode (
    input  vec_types_pkg::vopi_t  vopi,
    output vec_types_pkg::vexec_t vexec,
    output logic                  valid
);
    import vec_types_pkg::*;

    always_comb begin
        // ALU add by default
        vexec = '0;
        valid = 1'b1;
        case (vopi)
            VADD:       vexec.valuop = VALU_ADD;
            VSUB:       vexec.valuop = VALU_SUB;
            VRSUB:      vexec.valuop = VALU_RSUB;
            VMINU,
            VMIN:       vexec.valuop = VALU_MIN;
            VMAXU,
            VMAX:       vexec.valuop = VALU_MAX;
            VAND:       vexec.valuop = VALU_AND;
            VOR:        vexec.valuop = VALU_OR;
            VXOR:       vexec.valuop = VALU_XOR;
            VMERGE:     vexec.valuop = VALU_MERGE;
            VSLL:       vexec.valuop = VALU_SLL;
            // Narrowing shifts reuse the plain shifters
            VSRL,
            VNSRL:      vexec.valuop = VALU_SRL;
            VSRA,
            VNSRA:      vexec.valuop = VALU_SRA;
            VRGATHER:   vexec.vpermop = VPRM_GATHER;
            VSLIDEUP:   vexec.vpermop = VPRM_SLIDEUP;
            VSLIDEDOWN: vexec.vpermop = VPRM_SLIDEDOWN;
            VWREDSUMU,
            VWREDSUM:   vexec.vredop = VRED_SUM;
            // Reserved
            default:    valid = 1'b0;
        endcase

        // Unit follows the op group
        if (vopi inside {VRGATHER, VSLIDEUP, VSLIDEDOWN}) begin
            vexec.vfu = VFU_PRM;
        end else if (vopi inside {VWREDSUMU, VWREDSUM}) begin
            vexec.vfu = VFU_RED;
        end

        // Unsigned variants
        vexec.vopunsigned = vopi inside {VMINU, VMAXU, VSRL, VNSRL, VWREDSUMU};
    end

endmodule

// File: vec_opm_decode.sv
// #########################################################
// OPM funct6 decoder
// #########################################################
`timescale 1ns/100ps

module vec_opm_decode (
    input  vec_types_pkg::vopm_t  vopm,
    output vec_types_pkg::vexec_t vexec,
    output logic                  valid
);
    import vec_types_pkg::*;

    always_comb begin
        vexec = '0;
        valid = 1'b1;
        case (vopm)
            // Reductions
            VREDSUM:   vexec.vredop = VRED_SUM;
            VREDAND:   vexec.vredop = VRED_AND;
            VREDOR:    vexec.vredop = VRED_OR;
            VREDXOR:   vexec.vredop = VRED_XOR;
            VREDMINU,
            VREDMIN:   vexec.vredop = VRED_MIN;
            VREDMAXU,
            VREDMAX:   vexec.vredop = VRED_MAX;
            // Mask logicals
            VMANDN:    vexec.vmaskop = VMSK_ANDN;
            VMAND:     vexec.vmaskop = VMSK_AND;
            VMOR:      vexec.vmaskop = VMSK_OR;
            VMXOR:     vexec.vmaskop = VMSK_XOR;
            VMORN:     vexec.vmaskop = VMSK_ORN;
            VMNAND:    vexec.vmaskop = VMSK_NAND;
            VMNOR:     vexec.vmaskop = VMSK_NOR;
            VMXNOR:    vexec.vmaskop = VMSK_XNOR;
            // Multiplier, widening forms share the ops
            VMUL,
            VWMULU,
            VWMUL:     vexec.valuop = VALU_MUL;
            VMULHU,
            VMULH:     vexec.valuop = VALU_MULH;
            VMACC:     vexec.valuop = VALU_MACC;
            VNMSAC:    vexec.valuop = VALU_NMSAC;
            VWADDU,
            VWADD:     vexec.valuop = VALU_ADD;
            // Element move to scalar, no per-unit op
            VWXUNARY0: vexec.vfu = VFU_MOV;
            default:   valid = 1'b0;
        endcase

        if (vopm inside {[VREDSUM:VREDMAX]}) begin
            vexec.vfu = VFU_RED;
        end else if (vopm inside {[VMANDN:VMXNOR]}) begin
            vexec.vfu = VFU_MSK;
        end else if (vopm inside {VMUL, VMULHU, VMULH, VMACC, VNMSAC, VWMULU, VWMUL}) begin
            vexec.vfu = VFU_MUL;
        end

        vexec.vopunsigned = vopm inside {VREDMINU, VREDMAXU, VMULHU, VWADDU, VWMULU};
    end

endmodule

// File: vec_types_pkg.sv
// #########################################################
// Vector decode types
// #########################################################
`include "vec_consts.svh"

package vec_types_pkg;

    // Major opcodes of vector instructions
    typedef enum logic [6:0] {
        VMOC_LOAD    = 7'b0000111,
        VMOC_STORE   = 7'b0100111,
        VMOC_ALU_CFG = 7'b1010111
    } vmajoropcode_t;

    // Arithmetic format from funct3
    typedef enum logic [2:0] {
        OPIVV, OPFVV, OPMVV, OPIVI, OPIVX, OPFVF, OPMVX, OPCFG
    } vfunct3_t;

    // Memory addressing mode
    typedef enum logic [1:0] {
        MOP_UNIT, MOP_UINDEXED, MOP_STRIDED, MOP_OINDEXED
    } mop_t;

    // Memory element width field
    typedef enum logic [2:0] {
        WIDTH8  = 3'b000,
        WIDTH16 = 3'b101,
        WIDTH32 = 3'b110
    } width_t;

    typedef enum logic [1:0] {SEW8, SEW16, SEW32} vsew_t;

    // OPI funct6, narrowing shifts and widening reductions included
    typedef enum logic [5:0] {
        VADD = 6'b000000, VSUB = 6'b000010, VRSUB = 6'b000011,
        VMINU = 6'b000100, VMIN = 6'b000101, VMAXU = 6'b000110, VMAX = 6'b000111,
        VAND = 6'b001001, VOR = 6'b001010, VXOR = 6'b001011,
        VRGATHER = 6'b001100, VSLIDEUP = 6'b001110, VSLIDEDOWN = 6'b001111,
        VMERGE = 6'b010111, VSLL = 6'b100101, VSRL = 6'b101000, VSRA = 6'b101001,
        VNSRL = 6'b101100, VNSRA = 6'b101101,
        VWREDSUMU = 6'b110000, VWREDSUM = 6'b110001
    } vopi_t;

    // OPM funct6
    typedef enum logic [5:0] {
        VREDSUM = 6'b000000, VREDAND = 6'b000001, VREDOR = 6'b000010,
        VREDXOR = 6'b000011, VREDMINU = 6'b000100, VREDMIN = 6'b000101,
        VREDMAXU = 6'b000110, VREDMAX = 6'b000111, VWXUNARY0 = 6'b010000,
        VMANDN = 6'b011000, VMAND = 6'b011001, VMOR = 6'b011010, VMXOR = 6'b011011,
        VMORN = 6'b011100, VMNAND = 6'b011101, VMNOR = 6'b011110, VMXNOR = 6'b011111,
        VMULHU = 6'b100100, VMUL = 6'b100101, VMULH = 6'b100111,
        VMACC = 6'b101101, VNMSAC = 6'b101111,
        VWADDU = 6'b110000, VWADD = 6'b110001, VWMULU = 6'b111000, VWMUL = 6'b111011
    } vopm_t;

    // Execute unit select and per-unit operations
    typedef enum logic [2:0] {VFU_ALU, VFU_MUL, VFU_RED, VFU_MSK, VFU_PRM, VFU_MOV} vfu_t;

    typedef enum logic [3:0] {
        VALU_ADD, VALU_SUB, VALU_RSUB, VALU_MIN, VALU_MAX, VALU_AND, VALU_OR, VALU_XOR,
        VALU_SLL, VALU_SRL, VALU_SRA, VALU_MERGE, VALU_MUL, VALU_MULH, VALU_MACC, VALU_NMSAC
    } valuop_t;

    typedef enum logic [2:0] {
        VRED_SUM, VRED_AND, VRED_OR, VRED_XOR, VRED_MIN, VRED_MAX
    } vredop_t;

    typedef enum logic [2:0] {
        VMSK_AND, VMSK_NAND, VMSK_ANDN, VMSK_XOR, VMSK_OR, VMSK_NOR, VMSK_ORN, VMSK_XNOR
    } vmaskop_t;

    typedef enum logic [1:0] {VPRM_CPS, VPRM_GATHER, VPRM_SLIDEUP, VPRM_SLIDEDOWN} vpermop_t;

    // 16 bits
    typedef struct packed {
        vfu_t     vfu;
        valuop_t  valuop;
        vredop_t  vredop;
        vmaskop_t vmaskop;
        vpermop_t vpermop;
        logic     vopunsigned;
    } vexec_t;

    typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} vsetvl_t;

    typedef enum logic {RC_SCALAR, RC_VECTOR} regclass_t;

    typedef struct packed {
        regclass_t  regclass;
        logic [4:0] regidx;
    } regsel_t;

    // Full decoded bundle
    typedef struct packed {
        vsetvl_t                vsetvl_type;
        logic [10:0]            vtype_imm;
        logic [4:0]             vimm;
        regsel_t                vd_sel;
        regsel_t                vs1_sel;
        regsel_t                vs2_sel;
        logic                   sregwen;
        logic                   vregwen;
        logic                   vxin1_use_imm;
        logic                   vxin1_use_rs1;
        logic                   vxin2_use_rs2;
        vsew_t                  veew_src1;
        vsew_t                  veew_src2;
        vsew_t                  veew_dest;
        logic                   vmemrden;
        logic                   vmemwren;
        logic                   vunitstride;
        logic                   vstrided;
        logic                   vindexed;
        vexec_t                 vexec;
        logic [`VEC_VL_W-1:0]   vuop_num;
        logic                   vbank_offset;
        logic [`VEC_LANES-1:0]  vlaneactive;
    } vcontrol_t;

endpackage

// File: vec_uop_gen.sv
// #########################################################
// Micro-op generator
// #########################################################
`timescale 1ns/100ps
`include "vec_consts.svh"

module vec_uop_gen (
    input logic        CLK,
    input logic        reset,
    vec_uop_gen_if.gen vug_if
);
    import vec_types_pkg::*;

    localparam int LANE_SH = $clog2(`VEC_LANES);
    localparam int ROFF_W  = $clog2(`VEC_MAX_GROUP);
    // One extra bit for the rounding add
    localparam int CW      = `VEC_VL_W + 1;

    logic [`VEC_VL_W-1:0] uop_cnt;
    logic                 busy_q;
    logic [1:0]           word_shift;
    logic [2:0]           uop_shift;
    logic [CW-1:0]        uop_elems;
    logic [CW-1:0]        n_uops;
    logic [CW-1:0]        last_num;
    logic                 last_uop;
    logic [15:0]          lane_word;

    // Elements per 32-bit word as a shift
    always_comb begin
        case (vug_if.veew)
            SEW8:    word_shift = 2'd2;
            SEW16:   word_shift = 2'd1;
            default: word_shift = 2'd0;
        endcase
    end

    // Elements per micro-op, lanes times elements per word
    assign uop_shift = 3'(word_shift) + 3'(LANE_SH);
    assign uop_elems = CW'(1) << uop_shift;

    // Ceiling of vl over micro-op size
    assign n_uops   = (CW'(vug_if.vl) + uop_elems - CW'(1)) >> uop_shift;
    // vl of zero still issues one micro-op
    assign last_num = (n_uops == '0) ? '0 : n_uops - CW'(1);
    assign last_uop = ({1'b0, uop_cnt} == last_num);

    // Issue whenever a request or an instruction in flight is not stalled
    assign vug_if.issue = (vug_if.gen_valid || busy_q) && !vug_if.stall;
    assign vug_if.busy  = busy_q;

    always_ff @(posedge CLK) begin
        if (reset) begin
            uop_cnt <= '0;
            busy_q  <= 1'b0;
        end else if (vug_if.issue) begin
            if (last_uop) begin
                // Wrap for the next instruction
                uop_cnt <= '0;
                busy_q  <= 1'b0;
            end else begin
                uop_cnt <= uop_cnt + 1'b1;
                busy_q  <= 1'b1;
            end
        end
    end

    assign vug_if.vuop_num     = uop_cnt;
    assign vug_if.vbank_offset = uop_cnt[0];
    assign vug_if.vreg_offset  = ROFF_W'(uop_cnt >> LANE_SH);

    // Lane live when its first element index is below vl
    always_comb begin
        lane_word = '0;
        for (int i = 0; i < `VEC_LANES; i++) begin
            lane_word = (16'(uop_cnt) << LANE_SH) + 16'(i);
            vug_if.vlane_active[i] = (lane_word << word_shift) < 16'(vug_if.vl);
        end
    end

endmodule

// File: vec_uop_gen_if.sv
// #########################################################
// Micro-op generator link
// #########################################################
`timescale 1ns/100ps
`include "vec_consts.svh"

interface vec_uop_gen_if;
    import vec_types_pkg::*;

    // Request side
    logic                             gen_valid;
    logic                             stall;
    vsew_t                            veew;
    logic [`VEC_VL_W-1:0]             vl;

    // Per micro-op fields
    logic [`VEC_VL_W-1:0]             vuop_num;
    logic                             vbank_offset;
    logic [$clog2(`VEC_MAX_GROUP)-1:0] vreg_offset;
    logic [`VEC_LANES-1:0]            vlane_active;
    logic                             issue;
    logic                             busy;

    modport ctrl (
        output gen_valid, stall, veew, vl,
        input  vuop_num, vbank_offset, vreg_offset, vlane_active, issue, busy
    );

    modport gen (
        input  gen_valid, stall, veew, vl,
        output vuop_num, vbank_offset, vreg_offset, vlane_active, issue, busy
    );
endinterface
